// ==== Makefile ====
# Verilator build and run for the record sorter testbench

VERILATOR ?= verilator
TOP       ?= record_sorter_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator status is ignored here, the log decides pass or fail
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/sort_config.svh ====
/*
 * Record sorter configuration
 * Field widths of a record and the pipeline depth of the sorting network
 */

`ifndef SORT_CONFIG_SVH
`define SORT_CONFIG_SVH

// Width of the key that the network compares on
`define SORT_KEY_WIDTH 16

// Sideband fields that ride along with their key
`define SORT_USER_WIDTH 8
`define SORT_DEST_WIDTH 4

// Full record, key in the top bits
`define SORT_RECORD_WIDTH (`SORT_KEY_WIDTH + `SORT_USER_WIDTH + `SORT_DEST_WIDTH)

// Three stages in each half sorter plus three in the merger
`define SORT_LATENCY 6

`endif

// ==== common/sort_pkg.sv ====
/*
 * Record sorter types
 * Field and record vectors shared by the sorting network and its testbench
 */

`include "sort_config.svh"

package sort_pkg;

    // Sorting key, compared as an unsigned number
    typedef logic [`SORT_KEY_WIDTH-1:0] key_t;

    // Opaque user sideband, never inspected by the network
    typedef logic [`SORT_USER_WIDTH-1:0] user_t;

    // Destination tag, also carried through untouched
    typedef logic [`SORT_DEST_WIDTH-1:0] dest_t;

    // One record laid out as {key, user, dest}
    // Keeping the key on top lets the comparator slice it straight off the MSBs
    typedef logic [`SORT_RECORD_WIDTH-1:0] record_t;

endpackage

// ==== sorter_network/batcher_merger_8.sv ====
/*
 * Batcher odd-even merger for two sorted four-record lists
 * Produces eight records in ascending key order after three registered stages
 */

module batcher_merger_8 (
    input  logic              clock,
    input  sort_pkg::record_t low_half  [0:3],
    input  sort_pkg::record_t high_half [0:3],
    output sort_pkg::record_t data_out  [0:7]
);

    // Stage 1 pairs, element i of the low list against element i of the high list
    sort_pkg::record_t st1 [0:3][0:1];

    // Stage 1 results laid out in network position order
    sort_pkg::record_t pos1 [0:7];

    // Stage 2 pairs (2,4) and (3,5)
    sort_pkg::record_t st2 [0:1][0:1];

    // Records 0, 1, 6 and 7 skip stage 2
    sort_pkg::record_t skip2_q [0:3];

    // Stage 2 results laid out in network position order
    sort_pkg::record_t pos2 [0:7];

    // Stage 3 pairs (1,2), (3,4) and (5,6)
    sort_pkg::record_t st3 [0:2][0:1];

    // Records 0 and 7 skip stage 3
    sort_pkg::record_t skip3_q [0:1];

    // Stage 1 compares position i with position i+4
    for (genvar i = 0; i < 4; i++) begin : g_stage1
        sort_comparator u_cmp (
            .clock    (clock),
            .data_in  ('{low_half[i], high_half[i]}),
            .data_out (st1[i])
        );
    end

    // Minima go back to the lower positions, maxima to the upper ones
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            pos1[i]     = st1[i][0];
            pos1[i + 4] = st1[i][1];
        end
    end

    // Stage 2 compares position j+2 with j+4
    for (genvar j = 0; j < 2; j++) begin : g_stage2
        sort_comparator u_cmp (
            .clock    (clock),
            .data_in  ('{pos1[j + 2], pos1[j + 4]}),
            .data_out (st2[j])
        );
    end

    // The outer two records at each end are not touched in stage 2
    always_ff @(posedge clock) begin
        skip2_q[0] <= pos1[0];
        skip2_q[1] <= pos1[1];
        skip2_q[2] <= pos1[6];
        skip2_q[3] <= pos1[7];
    end

    always_comb begin
        pos2[0] = skip2_q[0];
        pos2[1] = skip2_q[1];
        pos2[2] = st2[0][0];
        pos2[3] = st2[1][0];
        pos2[4] = st2[0][1];
        pos2[5] = st2[1][1];
        pos2[6] = skip2_q[2];
        pos2[7] = skip2_q[3];
    end

    // Stage 3 cleans up the odd-even neighbours (2k+1, 2k+2)
    for (genvar k = 0; k < 3; k++) begin : g_stage3
        sort_comparator u_cmp (
            .clock    (clock),
            .data_in  ('{pos2[2 * k + 1], pos2[2 * k + 2]}),
            .data_out (st3[k])
        );
    end

    // Global minimum and maximum are settled after stage 1 already
    always_ff @(posedge clock) begin
        skip3_q[0] <= pos2[0];
        skip3_q[1] <= pos2[7];
    end

    always_comb begin
        data_out[0] = skip3_q[0];
        for (int k = 0; k < 3; k++) begin
            data_out[2 * k + 1] = st3[k][0];
            data_out[2 * k + 2] = st3[k][1];
        end
        data_out[7] = skip3_q[1];
    end

endmodule

// ==== sorter_network/batcher_sorter_4.sv ====
/*
 * Four-input Batcher sorting network
 * Sorts four records by key in three registered stages of compare-exchange
 */

module batcher_sorter_4 (
    input  logic              clock,
    input  sort_pkg::record_t data_in  [0:3],
    output sort_pkg::record_t data_out [0:3]
);

    // Stage 1 results, pair (0,1) and pair (2,3)
    sort_pkg::record_t st1_lo [0:1];
    sort_pkg::record_t st1_hi [0:1];

    // Stage 2 results, pair (0,2) and pair (1,3)
    sort_pkg::record_t st2_even [0:1];
    sort_pkg::record_t st2_odd  [0:1];

    // Stage 3 result for the middle pair (1,2)
    sort_pkg::record_t st3_mid [0:1];

    // Outer records 0 and 3 are already final after stage 2
    sort_pkg::record_t outer_q [0:1];

    // Stage 1 sorts neighbouring pairs
    sort_comparator u_cmp_01 (
        .clock    (clock),
        .data_in  ('{data_in[0], data_in[1]}),
        .data_out (st1_lo)
    );

    sort_comparator u_cmp_23 (
        .clock    (clock),
        .data_in  ('{data_in[2], data_in[3]}),
        .data_out (st1_hi)
    );

    // Stage 2 merges the two sorted pairs
    // The smaller of the two minima lands in slot 0, the larger of the two maxima in slot 3
    sort_comparator u_cmp_02 (
        .clock    (clock),
        .data_in  ('{st1_lo[0], st1_hi[0]}),
        .data_out (st2_even)
    );

    sort_comparator u_cmp_13 (
        .clock    (clock),
        .data_in  ('{st1_lo[1], st1_hi[1]}),
        .data_out (st2_odd)
    );

    // Stage 3 only has to fix up the two middle records
    sort_comparator u_cmp_12 (
        .clock    (clock),
        .data_in  ('{st2_odd[0], st2_even[1]}),
        .data_out (st3_mid)
    );

    // Outer records wait one cycle so all four leave together
    always_ff @(posedge clock) begin
        outer_q[0] <= st2_even[0];
        outer_q[1] <= st2_odd[1];
    end

    assign data_out = '{outer_q[0], st3_mid[0], st3_mid[1], outer_q[1]};

endmodule

// ==== sorter_network/sort_comparator.sv ====
/*
 * Compare-exchange element
 * Registers two records in ascending key order, one cycle of latency
 */

module sort_comparator (
    input  logic              clock,
    input  sort_pkg::record_t data_in  [0:1],
    output sort_pkg::record_t data_out [0:1]
);

    // Keys of the two incoming records
    sort_pkg::key_t key_a;
    sort_pkg::key_t key_b;

    // Set when the pair has to be exchanged
    logic swap;

    // The key sits in the most significant bits of the record
    assign key_a = data_in[0][$bits(sort_pkg::record_t)-1 -: $bits(sort_pkg::key_t)];
    assign key_b = data_in[1][$bits(sort_pkg::record_t)-1 -: $bits(sort_pkg::key_t)];

    // Strict compare, so equal keys stay where they are
    // User and destination bits never take part in the decision
    assign swap = key_b < key_a;

    // Pure data path register, the valid pipeline in the top level gives it meaning
    always_ff @(posedge clock) begin
        if (swap) begin
            data_out[0] <= data_in[1];
            data_out[1] <= data_in[0];
        end else begin
            data_out[0] <= data_in[0];
            data_out[1] <= data_in[1];
        end
    end

endmodule

// ==== source/record_sorter.sv ====
/*
 * Pipelined eight-record sorter
 * Sorts each half with a four-input Batcher network, merges the halves and
 * delays the batch strobe to line up with the sorted output
 */

`include "sort_config.svh"

module record_sorter (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              in_valid,
    input  sort_pkg::record_t in_records  [0:7],
    output logic              out_valid,
    output sort_pkg::record_t out_records [0:7]
);

    // Each half comes out of its sorter three cycles after it went in
    sort_pkg::record_t sorted_low  [0:3];
    sort_pkg::record_t sorted_high [0:3];

    // One flop per network stage, bit 0 is the newest batch
    logic [`SORT_LATENCY-1:0] valid_pipe;

    // Lower half of the batch, records 0 to 3
    batcher_sorter_4 u_sort_low (
        .clock    (clock),
        .data_in  (in_records[0:3]),
        .data_out (sorted_low)
    );

    // Upper half of the batch, records 4 to 7
    batcher_sorter_4 u_sort_high (
        .clock    (clock),
        .data_in  (in_records[4:7]),
        .data_out (sorted_high)
    );

    // Both halves reach the merger in the same cycle since the sorters share depth
    // The merger output is already registered, so it goes straight to the port
    batcher_merger_8 u_merge (
        .clock     (clock),
        .low_half  (sorted_low),
        .high_half (sorted_high),
        .data_out  (out_records)
    );

    // The data path has no reset and samples in_records on every edge
    // Only this strobe pipeline marks which cycles carry a real batch
    // A new batch can enter every cycle, so every bit may be set at once
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`SORT_LATENCY-2:0], in_valid};
        end
    end

    // Last flop lines up with the final merger stage
    assign out_valid = valid_pipe[`SORT_LATENCY-1];

endmodule

// ==== tb.f ====
+incdir+common
common/sort_pkg.sv
sorter_network/sort_comparator.sv
sorter_network/batcher_sorter_4.sv
sorter_network/batcher_merger_8.sv
source/record_sorter.sv
verification/sort_clock_gen.sv
verification/record_sorter_asserts.sv
verification/record_sorter_tb.sv

// ==== verification/record_sorter_asserts.sv ====
/*
 * Concurrent checks on the record sorter top level
 * Strobe timing against the pipeline depth and key order of every valid output batch
 */

`include "sort_config.svh"

module record_sorter_asserts (
    input logic              clock,
    input logic              rst_n,
    input logic              in_valid,
    input logic              out_valid,
    input sort_pkg::record_t out_records [0:7]
);

    // High when the eight output keys never step down from one index to the next
    logic keys_ordered;

    always_comb begin
        keys_ordered = 1'b1;
        for (int i = 0; i < 7; i++) begin
            // Key sits in the top bits of every record
            if (out_records[i + 1][`SORT_RECORD_WIDTH-1 -: `SORT_KEY_WIDTH] <
                out_records[i][`SORT_RECORD_WIDTH-1 -: `SORT_KEY_WIDTH]) begin
                keys_ordered = 1'b0;
            end
        end
    end

    // The strobe pipeline is cleared by reset, so no batch can leave during it
    a_quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !out_valid)
        else $error("out_valid high while rst_n is low");

    // Every accepted batch must leave exactly SORT_LATENCY cycles later
    a_batch_leaves: assert property (@(posedge clock) disable iff (!rst_n)
        $past(in_valid, `SORT_LATENCY) |-> out_valid)
        else $error("out_valid missing SORT_LATENCY cycles after in_valid");

    // And nothing leaves that did not enter SORT_LATENCY cycles before
    a_no_spurious: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> $past(in_valid, `SORT_LATENCY))
        else $error("out_valid without a matching in_valid");

    // The network sorts ascending on the key only
    a_keys_ordered: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> keys_ordered)
        else $error("out_records keys not in ascending order");

endmodule

// Attach the checks to every record_sorter instance
bind record_sorter record_sorter_asserts u_asserts (.*);

// ==== verification/record_sorter_tb.sv ====
/*
 * Testbench for the eight-record sorter
 * Reads batches and sorted results from the vectors file, drives them with idle gaps
 * and compares every output batch in order, keys only where a batch holds ties
 */

`include "sort_config.svh"

module record_sorter_tb;

    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_VECTORS  = 64;

    logic              clock;
    logic              rst_n;
    logic              in_valid;
    sort_pkg::record_t in_records  [0:7];
    logic              out_valid;
    sort_pkg::record_t out_records [0:7];

    // Vector table as read from the file
    int                vec_gap [0:MAX_VECTORS-1];
    bit                vec_tie [0:MAX_VECTORS-1];
    sort_pkg::record_t vec_in  [0:MAX_VECTORS-1][0:7];
    sort_pkg::record_t vec_exp [0:MAX_VECTORS-1][0:7];
    int                vec_count;
    int                max_gap;

    // Indices of the batches in flight with the oldest at the head
    int expected_q [$];

    // Rising-edge times at which those batches were driven
    time drive_time_q [$];

    bit vectors_loaded;
    int timeout_time;

    sort_clock_gen #(
        .PERIOD       (CLOCK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    record_sorter u_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_records  (in_records),
        .out_valid   (out_valid),
        .out_records (out_records)
    );

    // Records are laid out {key, user, dest} with the key in the top bits
    function automatic sort_pkg::key_t record_key(input sort_pkg::record_t rec);
        return rec[`SORT_RECORD_WIDTH-1 -: `SORT_KEY_WIDTH];
    endfunction

    task automatic abort_run(input string reason);
        if (reason.len() != 0) begin
            $display("%s", reason);
        end
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_record(input string name, input int idx,
                                input sort_pkg::record_t expected,
                                input sort_pkg::record_t actual);
        if (actual !== expected) begin
            $display("Fail %s[%0d] expected %h actual %h", name, idx, expected, actual);
            abort_run("");
        end
    endtask

    task automatic check_key(input string name, input int idx,
                             input sort_pkg::key_t expected,
                             input sort_pkg::key_t actual);
        if (actual !== expected) begin
            $display("Fail %s[%0d].key expected %h actual %h", name, idx, expected, actual);
            abort_run("");
        end
    endtask

    // Each data line holds gap, tie flag, eight inputs and eight sorted records
    task automatic load_vectors();
        int                fd;
        int                n;
        int                gap;
        int                tie;
        string             line;
        sort_pkg::record_t rec [0:15];
        fd = $fopen("verification/sort_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the vectors file verification/sort_vectors.txt");
        end
        vec_count = 0;
        max_gap   = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Blank lines and '#' comment lines carry no batch
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        gap, tie, rec[0], rec[1], rec[2], rec[3], rec[4], rec[5],
                        rec[6], rec[7], rec[8], rec[9], rec[10], rec[11], rec[12],
                        rec[13], rec[14], rec[15]);
            if (n != 18) begin
                abort_run($sformatf("Malformed line in the vectors file: %s", line));
            end
            if (vec_count == MAX_VECTORS) begin
                abort_run("The vectors file holds more batches than the testbench can store");
            end
            vec_gap[vec_count] = gap;
            vec_tie[vec_count] = (tie != 0);
            for (int i = 0; i < 8; i++) begin
                vec_in[vec_count][i]  = rec[i];
                vec_exp[vec_count][i] = rec[i + 8];
            end
            if (gap > max_gap) begin
                max_gap = gap;
            end
            vec_count++;
        end
        $fclose(fd);
        if (vec_count == 0) begin
            abort_run("The vectors file holds no batches");
        end
    endtask

    // Driver followed by the drain and the verdict
    initial begin
        in_valid <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            in_records[i] <= '0;
        end
        load_vectors();
        // Every batch may wait its gap plus one cycle, with reset, drain and margin on top
        timeout_time = (vec_count * (max_gap + 1) + `SORT_LATENCY + 20 + RESET_CYCLES)
                       * CLOCK_PERIOD;
        vectors_loaded = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge clock);
        for (int v = 0; v < vec_count; v++) begin
            // Idle cycles before this batch where zero means back to back with the last one
            repeat (vec_gap[v]) begin
                @(posedge clock);
                in_valid <= 1'b0;
            end
            @(posedge clock);
            in_valid <= 1'b1;
            for (int i = 0; i < 8; i++) begin
                in_records[i] <= vec_in[v][i];
            end
            expected_q.push_back(v);
            drive_time_q.push_back($time);
        end
        @(posedge clock);
        in_valid <= 1'b0;
        // Let the last batch leave the pipeline
        repeat (`SORT_LATENCY + 4) @(posedge clock);
        if (expected_q.size() != 0) begin
            abort_run($sformatf("%0d batches went in but never came out", expected_q.size()));
        end else begin
            $display("test passed");
            $finish;
        end
    end

    // The monitor looks on the falling edge while the outputs are stable
    initial begin
        int  idx;
        time driven_at;
        time due_at;
        forever begin
            @(negedge clock);
            if (rst_n === 1'b1 && out_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    abort_run("out_valid went high with no batch in flight");
                end
                idx       = expected_q.pop_front();
                driven_at = drive_time_q.pop_front();
                // The DUT samples a batch on the edge after it is driven and the last
                // of the SORT_LATENCY strobe flops loads it SORT_LATENCY-1 edges later
                due_at = driven_at + `SORT_LATENCY * CLOCK_PERIOD + CLOCK_PERIOD / 2;
                if ($time != due_at) begin
                    abort_run($sformatf("Batch %0d left at time %0d instead of time %0d",
                                        idx, $time, due_at));
                end
                for (int i = 0; i < 8; i++) begin
                    // Equal keys may leave in any order, so tie batches compare keys only
                    if (vec_tie[idx]) begin
                        check_key("out_records", i, record_key(vec_exp[idx][i]),
                                  record_key(out_records[i]));
                    end else begin
                        check_record("out_records", i, vec_exp[idx][i], out_records[i]);
                    end
                end
            end
        end
    end

    // Watchdog
    initial begin
        wait (vectors_loaded);
        #(timeout_time);
        abort_run($sformatf("Timeout after %0d time units because the run did not finish",
                            timeout_time));
    end

endmodule

// ==== verification/sort_clock_gen.sv ====
/*
 * Testbench clock and reset source
 * Free-running clock and an active-low reset held for a fixed number of cycles
 */

module sort_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic rst_n
);

    // Clock starts low so the first rising edge falls at half a period
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset is released on a rising edge, after the DUT has seen RESET_CYCLES edges in reset
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

// ==== verification/sort_vectors.txt ====
# gap tie in0..in7 exp0..exp7, each record 7 hex digits laid out {key16, user8, dest4}
# gap is the idle cycles before the batch, tie 1 means only the keys are compared
3 0 0010011 0020022 0030033 0040044 0050055 0060066 0070077 0080088 0010011 0020022 0030033 0040044 0050055 0060066 0070077 0080088
2 0 0080108 0070117 0060126 0050135 0040144 0030153 0020162 0010171 0010171 0020162 0030153 0040144 0050135 0060126 0070117 0080108
0 0 3a7c201 0b12212 f001223 7e44234 1234245 c0de256 5a5a267 9999278 0b12212 1234245 3a7c201 5a5a267 7e44234 9999278 c0de256 f001223
0 0 8000301 7fff312 0001323 fffe334 4000345 c000356 2000367 e000378 0001323 2000367 4000345 7fff312 8000301 c000356 e000378 fffe334
0 0 0444401 0111412 0888423 0222434 0777445 0333456 0666467 0555478 0111412 0222434 0333456 0444401 0555478 0666467 0777445 0888423
0 0 1000501 0900512 0800523 0700534 1100545 1200556 1300567 1400578 0700534 0800523 0900512 1000501 1100545 1200556 1300567 1400578
0 0 5000601 6000612 7000623 8000634 1000645 2000656 3000667 4000678 1000645 2000656 3000667 4000678 5000601 6000612 7000623 8000634
0 0 0001701 0003712 0005723 0007734 0002745 0004756 0006767 0008778 0001701 0002745 0003712 0004756 0005723 0006767 0007734 0008778
0 0 2b2b801 0c0c812 d1d1823 4e4e834 9f9f845 6a6a856 1717867 e8e8878 0c0c812 1717867 2b2b801 4e4e834 6a6a856 9f9f845 d1d1823 e8e8878
5 0 ffff000 0000fff 7fff901 8000912 0001ee3 fffe004 00ff925 ff00936 0000fff 0001ee3 00ff925 7fff901 8000912 ff00936 fffe004 ffff000
4 0 8001a01 7ffea12 ffffa23 0000a34 fffea45 0002a56 c3c3a67 3c3ca78 0000a34 0002a56 3c3ca78 7ffea12 8001a01 c3c3a67 fffea45 ffffa23
3 1 5555b01 5555b12 5555b23 5555b34 5555b45 5555b56 5555b67 5555b78 5555b01 5555b12 5555b23 5555b34 5555b45 5555b56 5555b67 5555b78
0 1 0000c01 0000c12 0000c23 0000c34 0000c45 0000c56 0000c67 0000c78 0000c01 0000c12 0000c23 0000c34 0000c45 0000c56 0000c67 0000c78
0 1 ffffd01 ffffd12 ffffd23 ffffd34 ffffd45 ffffd56 ffffd67 ffffd78 ffffd01 ffffd12 ffffd23 ffffd34 ffffd45 ffffd56 ffffd67 ffffd78
0 1 0003e01 0001e12 0003e23 0002e34 0001e45 0002e56 0003e67 0001e78 0001e12 0001e45 0001e78 0002e34 0002e56 0003e01 0003e23 0003e67
2 1 ffff101 0000112 ffff123 0000134 8000145 8000156 7fff167 7fff178 0000112 0000134 7fff167 7fff178 8000145 8000156 ffff101 ffff123
0 1 0042201 0042212 0042223 0042234 0042245 0042256 0042267 0041278 0041278 0042201 0042212 0042223 0042234 0042245 0042256 0042267
7 0 0500301 0200312 0700323 0100334 0800345 0300356 0600367 0400378 0100334 0200312 0300356 0400378 0500301 0600367 0700323 0800345
1 0 a001401 a000412 0fff423 1000434 b000445 0ffe456 a002467 1001478 0ffe456 0fff423 1000434 1001478 a000412 a001401 a002467 b000445
0 0 0002501 0001512 0004523 0003534 0006545 0005556 0008567 0007578 0001512 0002501 0003534 0004523 0005556 0006545 0007578 0008567
0 0 0010000 000fff0 0011001 000eff1 0012002 000dff2 0013003 000cff3 000cff3 000dff2 000eff1 000fff0 0010000 0011001 0012002 0013003
6 0 fff0601 0f0f612 f0f0623 00f0634 ff0f645 0ff0656 f00f667 000f678 000f678 00f0634 0f0f612 0ff0656 f00f667 f0f0623 ff0f645 fff0601
